/* sim.f */
+incdir+source
source/logpack_pkg.sv
source/logb_ingress.sv
source/logb_merge_node.sv
source/trace_writer.sv
source/logpack_top.sv
bench/logpack_tb.sv

/* bench/logpack_tb.sv */
`include "logpack_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module logpack_tb;

  localparam int clk_period   = 40;
  localparam int drive_dly    = 5;
  localparam int free_cycles  = 300;
  localparam int hold_cycles  = 10;
  localparam int drain_cycles = 290;
  localparam int stim_cycles  = free_cycles + hold_cycles + drain_cycles;
  // stimulus length plus margin for reset, quiesce and flush
  localparam int watchdog_ns  = stim_cycles * clk_period + 6000;

  logic                             clk;
  logic                             rstn;
  logpack_pkg::chan_mask_t          logb_valid;
  logic [`LP_FULL_W-1:0]            logb_data;
  logic                             logb_stall;
  logic                             trace_valid;
  logpack_pkg::packed_data_t        trace_data;
  logpack_pkg::packed_len_t         trace_len;
  logic                             trace_ready;

  logic [31:0]                      seed;
  logpack_pkg::packed_data_t        exp_data_q[$];
  logpack_pkg::packed_len_t         exp_len_q[$];
  logpack_pkg::packed_data_t        want_data;
  logpack_pkg::packed_len_t         want_len;
  int                               bp_count;
  int                               guard;

  logpack_top UUT (
    .clk         (clk),
    .rstn        (rstn),
    .logb_valid  (logb_valid),
    .logb_data   (logb_data),
    .logb_stall  (logb_stall),
    .trace_valid (trace_valid),
    .trace_data  (trace_data),
    .trace_len   (trace_len),
    .trace_ready (trace_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // first error ends the run
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] v);
    seed = lcg_next(seed);
    v = seed;
  endtask

  // valid channels land back to back from bit 0, in channel order
  function automatic logpack_pkg::packed_data_t pack_expected(
    input logpack_pkg::chan_mask_t m, input logic [`LP_FULL_W-1:0] d);
    logpack_pkg::packed_data_t r;
    int pos;
    r = '0;
    pos = 0;
    for (int c = 0; c < `LP_CHAN_CNT; c++) begin
      if (m[c]) begin
        r[pos +: `LP_CHAN_W] = d[c*`LP_CHAN_W +: `LP_CHAN_W];
        pos += `LP_CHAN_W;
      end
    end
    return r;
  endfunction

  function automatic logpack_pkg::packed_len_t len_expected(input logpack_pkg::chan_mask_t m);
    int n;
    n = 0;
    for (int c = 0; c < `LP_CHAN_CNT; c++) begin
      n += m[c];
    end
    return logpack_pkg::packed_len_t'(n * `LP_CHAN_W);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #(drive_dly);
  endtask

  // masked off while stalled, an accepted nonzero mask goes to the reference
  task automatic apply_inputs(input logpack_pkg::chan_mask_t mask,
                              input logic [`LP_FULL_W-1:0] data,
                              input logic ready);
    logpack_pkg::chan_mask_t m;
    m = logb_stall ? '0 : mask;
    logb_valid  = m;
    logb_data   = data;
    trace_ready = ready;
    if (m != '0) begin
      exp_data_q.push_back(pack_expected(m, data));
      exp_len_q.push_back(len_expected(m));
    end
  endtask

  // ready_odds is out of 256, force_any keeps at least one channel valid
  task automatic random_stim(input int ready_odds, input logic force_any);
    logic [31:0]             r;
    logpack_pkg::chan_mask_t mask;
    logic [`LP_FULL_W-1:0]   data;
    logic                    ready;
    draw(r);
    mask  = r[31:28];
    ready = (int'(r[27:20]) < ready_odds);
    if (force_any) begin
      mask = mask | (4'b0001 << r[19:18]);
    end
    for (int c = 0; c < `LP_CHAN_CNT; c++) begin
      draw(r);
      data[c*`LP_CHAN_W +: `LP_CHAN_W] = r[31:16];
    end
    apply_inputs(mask, data, ready);
  endtask

  // idle inputs with ready high until nothing is left in flight
  task automatic wait_drained();
    int n;
    n = 0;
    next_cycle();
    apply_inputs('0, '0, 1'b1);
    while ((trace_valid || exp_data_q.size() != 0) && n < 40) begin
      next_cycle();
      apply_inputs('0, '0, 1'b1);
      n++;
    end
    assert (!trace_valid && exp_data_q.size() == 0 && !logb_stall)
      else stop_run("trace FIFO did not drain, or credits did not come back");
  endtask

  //////////////////////////////////////////////////
  // output checks
  //////////////////////////////////////////////////

  // sampled mid-cycle, the handshake itself happens at the next rising edge
  always @(negedge clk) begin
    if (rstn && trace_valid && trace_ready) begin
      assert (exp_data_q.size() != 0)
        else stop_run("output handshake with no record outstanding");
      want_data = exp_data_q.pop_front();
      want_len  = exp_len_q.pop_front();
      assert (trace_len == want_len)
        else stop_run($sformatf("FAIL %0t ns: trace_len %0d, expected %0d",
                                $time, trace_len, want_len));
      // nothing may sit above the record length
      assert ((trace_data >> trace_len) == '0)
        else stop_run($sformatf("FAIL %0t ns: bits set above trace_len %0d",
                                $time, trace_len));
      assert (trace_data == want_data)
        else stop_run($sformatf("FAIL %0t ns: trace_data %h, expected %h",
                                $time, trace_data, want_data));
    end
  end

  hold_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    (trace_valid && !trace_ready) |=> (trace_valid && $stable(trace_data) && $stable(trace_len))
  ) else stop_run($sformatf("FAIL %0t ns: trace output changed while waiting for ready", $time));

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rstn          = 1'b0;
    logb_valid    = '0;
    logb_data     = '0;
    trace_ready   = 1'b0;
    seed          = 32'h9d46;
    repeat (2) @(posedge clk);
    #(drive_dly);
    rstn = 1'b1;

    // nothing can reach the output this early
    for (int i = 0; i < 3; i++) begin
      next_cycle();
      assert (!trace_valid && !logb_stall)
        else stop_run($sformatf("FAIL %0t ns: trace_valid or logb_stall high after reset", $time));
      apply_inputs('0, '0, 1'b1);
    end

    // free running, ready mostly high
    for (int i = 0; i < free_cycles; i++) begin
      next_cycle();
      random_stim(192, 1'b0);
    end

    // back-pressure from an empty FIFO, stall after exactly depth records
    wait_drained();
    bp_count = 0;
    next_cycle();
    while (!logb_stall && bp_count <= `LP_FIFO_DEPTH) begin
      random_stim(0, 1'b1);
      bp_count++;
      next_cycle();
    end
    apply_inputs('0, '0, 1'b0);
    assert (logb_stall && bp_count == `LP_FIFO_DEPTH)
      else stop_run($sformatf("FAIL %0t ns: stall after %0d records, expected %0d",
                              $time, bp_count, `LP_FIFO_DEPTH));
    for (int i = 0; i < hold_cycles; i++) begin
      next_cycle();
      assert (logb_stall)
        else stop_run($sformatf("FAIL %0t ns: logb_stall dropped with ready low", $time));
      random_stim(0, 1'b0);
    end

    // drain, the first pop hands back a credit
    next_cycle();
    apply_inputs('0, '0, 1'b1);
    guard = 0;
    next_cycle();
    while (logb_stall && guard < 4) begin
      apply_inputs('0, '0, 1'b1);
      next_cycle();
      guard++;
    end
    assert (!logb_stall) else stop_run("logb_stall did not fall after the drain started");
    apply_inputs('0, '0, 1'b1);
    for (int i = 0; i < drain_cycles; i++) begin
      next_cycle();
      random_stim(160, 1'b0);
    end

    // every accepted record has to come out before the end
    wait_drained();
    $display("Verification passed");
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    stop_run("timeout: the run did not finish within the watchdog limit");
  end

endmodule

`default_nettype wire

/* source/logpack_top.sv */
`include "logpack_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module logpack_top (
  input  wire                          clk,
  input  wire                          rstn,
  input  wire logpack_pkg::chan_mask_t logb_valid,
  input  wire [`LP_FULL_W-1:0]         logb_data,
  output logic                         logb_stall,
  output logic                         trace_valid,
  output logpack_pkg::packed_data_t    trace_data,
  output logpack_pkg::packed_len_t     trace_len,
  input  wire                          trace_ready
);

  localparam int leaf_len_w = $clog2(`LP_CHAN_W + 1);
  localparam int l1_w       = 2 * `LP_CHAN_W;
  localparam int l1_len_w   = $clog2(l1_w + 1);
  localparam int l1_cnt     = `LP_CHAN_CNT / 2;

  logpack_pkg::chan_mask_t                  leaf_valid;
  logic [`LP_FULL_W-1:0]                    leaf_data;
  logic [`LP_CHAN_CNT-1:0][leaf_len_w-1:0]  leaf_len;
  logic [l1_cnt-1:0]                        l1_valid;
  logic [l1_cnt-1:0][l1_w-1:0]              l1_data;
  logic [l1_cnt-1:0][l1_len_w-1:0]          l1_len;
  logic                                     root_valid;
  logpack_pkg::packed_data_t                root_data;
  logpack_pkg::packed_len_t                 root_len;
  logic                                     credit_return;

  //////////////////////////////////////////////////
  // ingress and leaves
  //////////////////////////////////////////////////

  logb_ingress u_ingress (
    .clk           (clk),
    .rstn          (rstn),
    .logb_valid    (logb_valid),
    .logb_data     (logb_data),
    .logb_stall    (logb_stall),
    .credit_return (credit_return),
    .leaf_valid    (leaf_valid),
    .leaf_data     (leaf_data)
  );

  // a valid leaf is always one full channel wide
  for (genvar i = 0; i < `LP_CHAN_CNT; i++) begin : g_leaf_len
    assign leaf_len[i] = leaf_valid[i] ? leaf_len_w'(`LP_CHAN_W) : '0;
  end

  //////////////////////////////////////////////////
  // merge tree, two layers
  //////////////////////////////////////////////////

  // layer 1 pairs leaves 0/1 and 2/3
  for (genvar n = 0; n < l1_cnt; n++) begin : g_layer1
    logb_merge_node #(
      .width_a (`LP_CHAN_W),
      .width_b (`LP_CHAN_W)
    ) u_node (
      .clk       (clk),
      .rstn      (rstn),
      .a_valid   (leaf_valid[2*n]),
      .a_data    (leaf_data[2*n*`LP_CHAN_W +: `LP_CHAN_W]),
      .a_len     (leaf_len[2*n]),
      .b_valid   (leaf_valid[2*n+1]),
      .b_data    (leaf_data[(2*n+1)*`LP_CHAN_W +: `LP_CHAN_W]),
      .b_len     (leaf_len[2*n+1]),
      .out_valid (l1_valid[n]),
      .out_data  (l1_data[n]),
      .out_len   (l1_len[n])
    );
  end

  // root joins the two halves into the full record
  logb_merge_node #(
    .width_a (l1_w),
    .width_b (l1_w)
  ) u_root (
    .clk       (clk),
    .rstn      (rstn),
    .a_valid   (l1_valid[0]),
    .a_data    (l1_data[0]),
    .a_len     (l1_len[0]),
    .b_valid   (l1_valid[1]),
    .b_data    (l1_data[1]),
    .b_len     (l1_len[1]),
    .out_valid (root_valid),
    .out_data  (root_data),
    .out_len   (root_len)
  );

  //////////////////////////////////////////////////
  // trace writer
  //////////////////////////////////////////////////

  trace_writer u_writer (
    .clk           (clk),
    .rstn          (rstn),
    .in_valid      (root_valid),
    .in_data       (root_data),
    .in_len        (root_len),
    .trace_valid   (trace_valid),
    .trace_data    (trace_data),
    .trace_len     (trace_len),
    .trace_ready   (trace_ready),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

/* source/trace_writer.sv */
`include "logpack_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module trace_writer (
  input  wire                            clk,
  input  wire                            rstn,
  input  wire                            in_valid,
  input  wire logpack_pkg::packed_data_t in_data,
  input  wire logpack_pkg::packed_len_t  in_len,
  output logic                           trace_valid,
  output logpack_pkg::packed_data_t      trace_data,
  output logpack_pkg::packed_len_t       trace_len,
  input  wire                            trace_ready,
  output logic                           credit_return
);

  localparam int depth = `LP_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  //////////////////////////////////////////////////
  // trace fifo storage
  //////////////////////////////////////////////////

  logpack_pkg::packed_data_t data_mem [depth];
  logpack_pkg::packed_len_t  len_mem  [depth];

  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logpack_pkg::credit_t fill;
  logic                 push;
  logic                 pop;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    logic [ptr_w-1:0] nxt;
    if (p == ptr_w'(depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = p + 1'b1;
    end
    return nxt;
  endfunction

  // every valid root output is a non-empty record
  assign push = in_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= in_data;
      len_mem[wr_ptr]  <= in_len;
    end
  end

  //////////////////////////////////////////////////
  // pointers and fill level
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // valid/ready output and credit return
  //////////////////////////////////////////////////

  // head entry stays put until the sink takes it
  assign trace_valid   = (fill != '0);
  assign trace_data    = data_mem[rd_ptr];
  assign trace_len     = len_mem[rd_ptr];
  assign pop           = trace_valid && trace_ready;
  assign credit_return = pop;

  // the ingress credit loop must keep the fifo from overflowing
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rstn)
    push |-> (fill < logpack_pkg::credit_t'(depth))
  ) else $error("trace fifo push while full");

endmodule

`default_nettype wire

/* source/logb_merge_node.sv */
`timescale 1ns/100ps
`default_nettype none

module logb_merge_node #(
  parameter int width_a = 16,
  parameter int width_b = 16
) (
  input  wire                                      clk,
  input  wire                                      rstn,
  input  wire                                      a_valid,
  input  wire [width_a-1:0]                        a_data,
  input  wire [$clog2(width_a+1)-1:0]              a_len,
  input  wire                                      b_valid,
  input  wire [width_b-1:0]                        b_data,
  input  wire [$clog2(width_b+1)-1:0]              b_len,
  output logic                                     out_valid,
  output logic [width_a+width_b-1:0]               out_data,
  output logic [$clog2(width_a+width_b+1)-1:0]     out_len
);

  localparam int width_o = width_a + width_b;
  localparam int len_a_w = $clog2(width_a + 1);
  localparam int len_b_w = $clog2(width_b + 1);
  localparam int len_o_w = $clog2(width_o + 1);

  //////////////////////////////////////////////////
  // input stage, one cycle per node
  //////////////////////////////////////////////////

  logic               a_valid_q;
  logic [width_a-1:0] a_data_q;
  logic [len_a_w-1:0] a_len_q;
  logic               b_valid_q;
  logic [width_b-1:0] b_data_q;
  logic [len_b_w-1:0] b_len_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      a_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      a_valid_q <= a_valid;
      b_valid_q <= b_valid;
    end
  end

  always_ff @(posedge clk) begin
    a_data_q <= a_data;
    a_len_q  <= a_len;
    b_data_q <= b_data;
    b_len_q  <= b_len;
  end

  //////////////////////////////////////////////////
  // packing
  //////////////////////////////////////////////////

  logic [width_a-1:0] a_data_m;
  logic [len_a_w-1:0] a_len_m;
  logic [width_b-1:0] b_data_m;
  logic [len_b_w-1:0] b_len_m;

  // an idle side contributes no bits and no length
  // side a sits at bit 0, side b right above a's length
  // each side is already zero above its own length, so an OR is enough
  always_comb begin
    a_data_m = a_valid_q ? a_data_q : '0;
    a_len_m  = a_valid_q ? a_len_q : '0;
    b_data_m = b_valid_q ? b_data_q : '0;
    b_len_m  = b_valid_q ? b_len_q : '0;
    out_len  = len_o_w'(a_len_m) + len_o_w'(b_len_m);
    out_data = width_o'(a_data_m) | (width_o'(b_data_m) << a_len_m);
  end

  assign out_valid = a_valid_q | b_valid_q;

  // upstream must never claim more bits than its bus holds
  a_len_a_fits: assert property (
    @(posedge clk) disable iff (!rstn)
    a_valid_q |-> (a_len_q <= len_a_w'(width_a))
  ) else $error("side a len exceeds width");

  a_len_b_fits: assert property (
    @(posedge clk) disable iff (!rstn)
    b_valid_q |-> (b_len_q <= len_b_w'(width_b))
  ) else $error("side b len exceeds width");

endmodule

`default_nettype wire

/* source/logb_ingress.sv */
`include "logpack_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module logb_ingress (
  input  wire                          clk,
  input  wire                          rstn,
  input  wire logpack_pkg::chan_mask_t logb_valid,
  input  wire [`LP_FULL_W-1:0]         logb_data,
  output logic                         logb_stall,
  input  wire                          credit_return,
  output logpack_pkg::chan_mask_t      leaf_valid,
  output logic [`LP_FULL_W-1:0]        leaf_data
);

  //////////////////////////////////////////////////
  // leaf capture
  //////////////////////////////////////////////////

  logpack_pkg::credit_t credits;
  logic                 accept;

  // a record is taken only when some channel is valid and we hold a credit
  assign accept     = (|logb_valid) && !logb_stall;
  assign logb_stall = (credits == '0);

  // valids go straight into the leaves, masked off while stalled
  always_ff @(posedge clk) begin
    if (!rstn) begin
      leaf_valid <= '0;
    end else begin
      leaf_valid <= logb_stall ? '0 : logb_valid;
    end
  end

  // payload only means something where leaf_valid is set
  always_ff @(posedge clk) begin
    leaf_data <= logb_data;
  end

  //////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////

  // one credit per free trace fifo entry, including records still in the tree
  always_ff @(posedge clk) begin
    if (!rstn) begin
      credits <= logpack_pkg::credit_t'(`LP_FIFO_DEPTH);
    end else begin
      case ({accept, credit_return})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        // spend and return together cancel out
        default: credits <= credits;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // writer never returns more credits than were handed out
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rstn)
    credits <= logpack_pkg::credit_t'(`LP_FIFO_DEPTH)
  ) else $error("credit count above fifo depth");

  // producers have to honour the stall flag
  a_no_valid_in_stall: assert property (
    @(posedge clk) disable iff (!rstn)
    logb_stall |-> (logb_valid == '0)
  ) else $error("logb_valid presented while stalled");

endmodule

`default_nettype wire

/* source/logpack_pkg.sv */
`include "logpack_cfg.svh"
`default_nettype none

package logpack_pkg;

  // one channel record
  typedef logic [`LP_CHAN_W-1:0] chan_data_t;

  // one valid bit per channel, bit i is channel i
  typedef logic [`LP_CHAN_CNT-1:0] chan_mask_t;

  // fully packed record, unused upper bits are zero
  typedef logic [`LP_FULL_W-1:0] packed_data_t;

  // packed length in bits, must reach LP_FULL_W itself
  typedef logic [$clog2(`LP_FULL_W + 1)-1:0] packed_len_t;

  // credits 0 .. LP_FIFO_DEPTH inclusive
  typedef logic [$clog2(`LP_FIFO_DEPTH + 1)-1:0] credit_t;

endpackage

`default_nettype wire

/* source/logpack_cfg.svh */
`ifndef LOGPACK_CFG_SVH
`define LOGPACK_CFG_SVH

//////////////////////////////////////////////////
// logging channel geometry
//////////////////////////////////////////////////

// number of logb channels feeding the merge tree
`define LP_CHAN_CNT 4

// every channel carries one record of this many bits
`define LP_CHAN_W 16

// all channels valid at once, packed back to back
`define LP_FULL_W (`LP_CHAN_CNT * `LP_CHAN_W)

// trace fifo entries, which is also the initial credit count
`define LP_FIFO_DEPTH 8

`endif
